//--- logic/riscv_pkg.sv
package riscv_pkg;

  // ====================================================================
  // widths and constants
  // ====================================================================

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // ====================================================================
  // encodings
  // ====================================================================

  // values match the opcode field of the instruction word
  typedef enum logic [6:0] {
    OPC_REG     = 7'b0110011,
    OPC_IMM     = 7'b0010011,
    OPC_LUI     = 7'b0110111,
    OPC_ILLEGAL = 7'b0000000
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_e;

  // ====================================================================
  // pipeline register contents
  // ====================================================================

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  alu_src_imm;
    logic                  lui;
    logic                  reg_write;
  } id_exe_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       imm;
    logic                  lui;
    logic                  reg_write;
  } exe_mem_t;

  // also used for the memory-stage forwarding path
  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
  parameter logic [riscv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [riscv_pkg::XLEN-1:0] inst_i,
  output logic [riscv_pkg::XLEN-1:0] pc_o,
  output riscv_pkg::if_id_t          if_id_o
);

  logic [riscv_pkg::XLEN-1:0] pc_q;

  // straight-line fetch, no redirects
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_q + riscv_pkg::XLEN'(4);
    end
  end

  // ====================================================================
  // fetch to decode register
  // ====================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      if_id_o <= '{pc: RESET_PC, inst: riscv_pkg::NOP_INST};
    end else begin
      // the word answers the address shown this cycle
      if_id_o <= '{pc: pc_q, inst: inst_i};
    end
  end

  assign pc_o = pc_q;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [riscv_pkg::XLEN-1:0]       rdata1_o,
  output logic [riscv_pkg::XLEN-1:0]       rdata2_o,
  input  riscv_pkg::wb_t                   wb_i
);

  // x0 has no storage
  logic [riscv_pkg::XLEN-1:0] regs [1:31];

  // writeback never carries rd 0, decode filters it
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // asynchronous reads
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  riscv_pkg::if_id_t   if_id_i,
  input  riscv_pkg::wb_t      wb_i,
  output riscv_pkg::id_exe_t  id_exe_o
);

  logic [riscv_pkg::XLEN-1:0]       inst;
  logic [6:0]                       opcode_f;
  logic [2:0]                       funct3;
  logic [6:0]                       funct7;
  logic [riscv_pkg::REG_ADDR_W-1:0] rs1;
  logic [riscv_pkg::REG_ADDR_W-1:0] rs2;
  logic [riscv_pkg::REG_ADDR_W-1:0] rd;
  riscv_pkg::opcode_e               opc;
  riscv_pkg::alu_op_e               alu_op;
  logic [riscv_pkg::XLEN-1:0]       imm;
  logic [riscv_pkg::XLEN-1:0]       rf_rdata1;
  logic [riscv_pkg::XLEN-1:0]       rf_rdata2;
  logic [riscv_pkg::XLEN-1:0]       rdata1;
  logic [riscv_pkg::XLEN-1:0]       rdata2;
  logic                             reg_write;

  // instruction fields
  assign inst     = if_id_i.inst;
  assign opcode_f = inst[6:0];
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1      = inst[19:15];
  assign rs2      = inst[24:20];
  assign funct7   = inst[31:25];

  // ====================================================================
  // control decode
  // ====================================================================

  always_comb begin
    case (opcode_f)
      riscv_pkg::OPC_REG, riscv_pkg::OPC_IMM, riscv_pkg::OPC_LUI:
        opc = riscv_pkg::opcode_e'(opcode_f);
      default:
        opc = riscv_pkg::OPC_ILLEGAL;
    endcase
  end

  always_comb begin
    case (funct3)
      // sub only exists in register form
      3'b000:  alu_op = (opc == riscv_pkg::OPC_REG && funct7[5]) ? riscv_pkg::SUB
                                                                 : riscv_pkg::ADD;
      3'b001:  alu_op = riscv_pkg::SLL;
      3'b010:  alu_op = riscv_pkg::SLT;
      3'b011:  alu_op = riscv_pkg::SLTU;
      3'b100:  alu_op = riscv_pkg::XOR;
      // srai carries the same funct7 bit as sra
      3'b101:  alu_op = funct7[5] ? riscv_pkg::SRA : riscv_pkg::SRL;
      3'b110:  alu_op = riscv_pkg::OR;
      default: alu_op = riscv_pkg::AND;
    endcase
  end

  // U form for lui, I form otherwise
  assign imm = (opc == riscv_pkg::OPC_LUI) ? {inst[31:12], 12'b0}
                                           : {{20{inst[31]}}, inst[31:20]};

  // x0 targets and illegal words retire as bubbles
  assign reg_write = (opc != riscv_pkg::OPC_ILLEGAL) && (rd != '0);

  reg_file u_reg_file (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .wb_i     (wb_i)
  );

  // same-cycle writeback bypass
  assign rdata1 = (wb_i.valid && wb_i.rd == rs1) ? wb_i.data : rf_rdata1;
  assign rdata2 = (wb_i.valid && wb_i.rd == rs2) ? wb_i.data : rf_rdata2;

  // ====================================================================
  // decode to execute register
  // ====================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_exe_o <= '{rs1: '0, rs2: '0, rd: '0, rdata1: '0, rdata2: '0, imm: '0,
                    alu_op: riscv_pkg::ADD, alu_src_imm: 1'b1, lui: 1'b0,
                    reg_write: 1'b0};
    end else begin
      id_exe_o <= '{rs1: rs1, rs2: rs2, rd: rd, rdata1: rdata1, rdata2: rdata2,
                    imm: imm, alu_op: alu_op,
                    alu_src_imm: (opc != riscv_pkg::OPC_REG),
                    lui: (opc == riscv_pkg::OPC_LUI), reg_write: reg_write};
    end
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
  input  riscv_pkg::alu_op_e         op_i,
  input  logic [riscv_pkg::XLEN-1:0] a_i,
  input  logic [riscv_pkg::XLEN-1:0] b_i,
  output logic [riscv_pkg::XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      riscv_pkg::ADD:  result_o = a_i + b_i;
      riscv_pkg::SUB:  result_o = a_i - b_i;
      riscv_pkg::SLL:  result_o = a_i << shamt;
      riscv_pkg::SLT:  result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_signed};
      riscv_pkg::SLTU: result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_unsigned};
      riscv_pkg::XOR:  result_o = a_i ^ b_i;
      riscv_pkg::SRL:  result_o = a_i >> shamt;
      // arithmetic, keeps the sign bit
      riscv_pkg::SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      riscv_pkg::OR:   result_o = a_i | b_i;
      riscv_pkg::AND:  result_o = a_i & b_i;
      default:         result_o = '0;
    endcase
  end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  riscv_pkg::id_exe_t  id_exe_i,
  input  riscv_pkg::wb_t      mem_fwd_i,
  input  riscv_pkg::wb_t      wb_i,
  output riscv_pkg::exe_mem_t exe_mem_o
);

  logic [riscv_pkg::XLEN-1:0] fwd_a;
  logic [riscv_pkg::XLEN-1:0] fwd_b;
  logic [riscv_pkg::XLEN-1:0] op_b;
  logic [riscv_pkg::XLEN-1:0] alu_result;

  // ====================================================================
  // forwarding
  // ====================================================================

  // memory stage is younger than writeback, so it wins
  function automatic logic [riscv_pkg::XLEN-1:0] fwd_sel(
    input logic [riscv_pkg::REG_ADDR_W-1:0] rs,
    input logic [riscv_pkg::XLEN-1:0]       dec_val,
    input riscv_pkg::wb_t                   mem_src,
    input riscv_pkg::wb_t                   wb_src
  );
    logic [riscv_pkg::XLEN-1:0] val;
    if (mem_src.valid && mem_src.rd == rs) begin
      val = mem_src.data;
    end else if (wb_src.valid && wb_src.rd == rs) begin
      val = wb_src.data;
    end else begin
      val = dec_val;
    end
    return val;
  endfunction

  assign fwd_a = fwd_sel(id_exe_i.rs1, id_exe_i.rdata1, mem_fwd_i, wb_i);
  assign fwd_b = fwd_sel(id_exe_i.rs2, id_exe_i.rdata2, mem_fwd_i, wb_i);

  // immediate forms take the second operand from imm
  assign op_b = id_exe_i.alu_src_imm ? id_exe_i.imm : fwd_b;

  alu u_alu (
    .op_i     (id_exe_i.alu_op),
    .a_i      (fwd_a),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  // ====================================================================
  // execute to memory register
  // ====================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exe_mem_o <= '{rd: '0, alu_result: '0, imm: '0, lui: 1'b0, reg_write: 1'b0};
    end else begin
      exe_mem_o <= '{rd:         id_exe_i.rd,
                     alu_result: alu_result,
                     imm:        id_exe_i.imm,
                     lui:        id_exe_i.lui,
                     reg_write:  id_exe_i.reg_write};
    end
  end

endmodule

//--- logic/retire_stage.sv
`timescale 1ns/1ns

module retire_stage (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  riscv_pkg::exe_mem_t exe_mem_i,
  output riscv_pkg::wb_t      mem_fwd_o,
  output riscv_pkg::wb_t      wb_o
);

  logic [riscv_pkg::XLEN-1:0] result;

  // lui writes its immediate untouched
  assign result = exe_mem_i.lui ? exe_mem_i.imm : exe_mem_i.alu_result;

  // memory-stage view for the execute forwarding
  assign mem_fwd_o = '{valid: exe_mem_i.reg_write, rd: exe_mem_i.rd, data: result};

  // ====================================================================
  // memory to writeback register
  // ====================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_o <= '{valid: 1'b0, rd: '0, data: '0};
    end else begin
      wb_o <= mem_fwd_o;
    end
  end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
  parameter logic [riscv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [riscv_pkg::XLEN-1:0] inst_i,
  output logic [riscv_pkg::XLEN-1:0] current_pc_o,
  output riscv_pkg::wb_t             wb_o
);

  riscv_pkg::if_id_t   if_id;
  riscv_pkg::id_exe_t  id_exe;
  riscv_pkg::exe_mem_t exe_mem;
  riscv_pkg::wb_t      mem_fwd;

  // ====================================================================
  // five stages, one cycle each
  // ====================================================================

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .inst_i   (inst_i),
    .pc_o     (current_pc_o),
    .if_id_o  (if_id)
  );

  // wb_o also feeds the register file and the bypasses
  decode_stage u_decode (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .if_id_i  (if_id),
    .wb_i     (wb_o),
    .id_exe_o (id_exe)
  );

  execute_stage u_execute (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .id_exe_i  (id_exe),
    .mem_fwd_i (mem_fwd),
    .wb_i      (wb_o),
    .exe_mem_o (exe_mem)
  );

  retire_stage u_retire (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .exe_mem_i (exe_mem),
    .mem_fwd_o (mem_fwd),
    .wb_o      (wb_o)
  );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
  end

  // 4 ns period
  always #2 clk_o = ~clk_o;

  // release after three rising edges
  initial begin
    repeat (3) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- test/rv_core_chk.sv
`timescale 1ns/1ns

module rv_core_chk (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic [riscv_pkg::XLEN-1:0] pc_i,
  input riscv_pkg::wb_t             wb_i
);

  logic [2:0] cyc_q;

  // count of failed assertions
  int n_err = 0;

  // cycles since reset release, saturating
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_q <= '0;
    end else if (cyc_q != 3'd7) begin
      cyc_q <= cyc_q + 3'd1;
    end
  end

  // pipeline still holds reset bubbles
  no_early_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cyc_q < 3'd4) |-> !wb_i.valid)
    else begin
      $error("writeback valid within four cycles of reset");
      n_err++;
    end

  pc_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(arst_n_i) |-> pc_i == $past(pc_i) + riscv_pkg::XLEN'(4))
    else begin
      $error("pc did not advance by 4");
      n_err++;
    end

  wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_i.valid |-> wb_i.rd != '0)
    else begin
      $error("writeback to x0");
      n_err++;
    end

endmodule

bind rv_core rv_core_chk u_chk (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .pc_i     (current_pc_o),
  .wb_i     (wb_o)
);

//--- test/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;

  localparam logic [31:0] RESET_PC  = 32'h0000_0100;
  localparam int          MAX_WORDS = 64;

  logic                       clk;
  logic                       arst_n;
  logic [riscv_pkg::XLEN-1:0] inst;
  logic [riscv_pkg::XLEN-1:0] current_pc;
  logic [31:0]                fetch_idx;
  riscv_pkg::wb_t             wb;

  // per program word: instruction, expected rd (0 for none), expected data
  logic [31:0] tdata [0:3*MAX_WORDS-1];

  int   n_words;
  int   n_exp;
  int   limit;
  int   n_seen   = 0;
  int   next_exp = 0;
  int   n_pass   = 0;
  int   n_fail   = 0;
  int   cycle    = 0;
  logic ok;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rv_core #(
    .RESET_PC (RESET_PC)
  ) DUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .inst_i       (inst),
    .current_pc_o (current_pc),
    .wb_o         (wb)
  );

  // unloaded slots keep an address-dependent marker
  function automatic logic [31:0] fill_word(input int addr);
    return 32'hBAD0_0000 ^ addr;
  endfunction

  // same-cycle instruction port, nops past the program
  assign fetch_idx = (current_pc - RESET_PC) >> 2;
  assign inst      = (fetch_idx < 32'(n_words)) ? tdata[3*fetch_idx] : riscv_pkg::NOP_INST;

  initial begin
    for (int i = 0; i < 3*MAX_WORDS; i++) begin
      tdata[i] = fill_word(i);
    end
    $readmemh("test/rv_core_testdata.txt", tdata);
    n_words = 0;
    n_exp   = 0;
    while (n_words < MAX_WORDS && tdata[3*n_words] != fill_word(3*n_words)) begin
      if (tdata[3*n_words+1] != 0) begin
        n_exp++;
      end
      n_words++;
    end
    limit = n_words + 20;
    assert (n_exp > 0) else begin
      $display("no expected writebacks were loaded from the data file");
      n_fail++;
    end
  end

  // ====================================================================
  // scoreboard
  // ====================================================================

  // word i enters fetch in cycle i and retires in cycle i+4
  task automatic check_writeback();
    logic [31:0] exp_rd;
    logic [31:0] exp_data;
    while (next_exp < n_words && tdata[3*next_exp+1] == 0) begin
      next_exp++;
    end
    assert (next_exp < n_words) else begin
      $display("unexpected writeback to x%0d at %0t after the last expected one", wb.rd, $time);
      n_fail++;
    end
    if (next_exp < n_words) begin
      exp_rd   = tdata[3*next_exp+1];
      exp_data = tdata[3*next_exp+2];
      ok = (32'(wb.rd) == exp_rd) && (wb.data == exp_data) && (cycle == next_exp + 4);
      assert (ok) else begin
        $display("[ERROR] %0t: word %0d wrote x%0d = %h in cycle %0d, expected x%0d = %h in %0d",
                 $time, next_exp, wb.rd, wb.data, cycle, exp_rd, exp_data, next_exp + 4);
        n_fail++;
      end
      if (ok) begin
        n_pass++;
      end
      $display("test %0d x%0d: %s", next_exp, exp_rd, ok ? "ok" : "mismatch");
      n_seen++;
      next_exp++;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    if (timed_out) begin
      $display("timeout: %0d of %0d writebacks seen after %0d cycles", n_seen, n_exp, cycle);
    end
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             n_pass, n_fail, DUT.u_chk.n_err);
    if (n_fail == 0 && DUT.u_chk.n_err == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // wb_o is settled at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (wb.valid) begin
        check_writeback();
      end
      if (n_seen == n_exp && cycle >= n_words + 4) begin
        finish_run(1'b0);
      end else if (cycle >= limit) begin
        finish_run(1'b1);
      end else begin
        cycle++;
      end
    end
  end

endmodule

//--- test/rv_core_testdata.txt
// columns: instruction word, expected rd (00 = no writeback), expected data
// one word per line, fetched from RESET_PC upward
00500093 01 00000005  // addi x1, x0, 5
FFD00113 02 FFFFFFFD  // addi x2, x0, -3
002081B3 03 00000002  // add  x3, x1, x2
40208233 04 00000008  // sub  x4, x1, x2
001122B3 05 00000001  // slt  x5, x2, x1
00113333 06 00000000  // sltu x6, x2, x1
001093B3 07 000000A0  // sll  x7, x1, x1
00315433 08 3FFFFFFF  // srl  x8, x2, x3
403154B3 09 FFFFFFFF  // sra  x9, x2, x3
0020C533 0A FFFFFFF8  // xor  x10, x1, x2
0020E5B3 0B FFFFFFFD  // or   x11, x1, x2
0020F633 0C 00000005  // and  x12, x1, x2
123456B7 0D 12345000  // lui  x13, 0x12345
67868693 0D 12345678  // addi x13, x13, 0x678
FFF6C713 0E EDCBA987  // xori x14, x13, -1
FFE12793 0F 00000001  // slti x15, x2, -2
FFF0B813 10 00000001  // sltiu x16, x1, -1
40115893 11 FFFFFFFE  // srai x17, x2, 1
0FF6F913 12 00000078  // andi x18, x13, 0xff
00475993 13 0EDCBA98  // srli x19, x14, 4
00708013 00 00000000  // addi x0, x1, 7
00002F83 00 00000000  // lw x31, 0(x0), illegal here
000F8A33 14 00000000  // add  x20, x31, x0

//--- list.f
logic/riscv_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/alu.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/rv_core.sv
test/tb_clk_gen.sv
test/rv_core_chk.sv
test/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -f list.f -o rv_core_sim
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
  exit 1
fi
